// ==== design/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // data path.
    localparam int xlen = 64;
    localparam int strb_w = xlen / 8;

    // byte address on the bus, word address on the core side.
    localparam int addr_w = 32;
    localparam int offset_w = 3;
    localparam int word_addr_w = addr_w - offset_w;

    // axi response codes.
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_t;

endpackage

`default_nettype wire

// ==== design/data_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_cache import lsu_pkg::*; #(
    parameter int index_w = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [word_addr_w-1:0] lookup_addr,
    output logic                   hit,
    output logic [xlen-1:0]        rdata,
    input  logic                   write_en,
    input  logic [word_addr_w-1:0] write_addr,
    input  logic [xlen-1:0]        write_data,
    input  logic [strb_w-1:0]      write_strb,
    input  logic                   fill
);

    localparam int tag_w = word_addr_w - index_w;
    localparam int lines = 1 << index_w;

    logic [lines-1:0]       valid_q;
    logic [tag_w-1:0]       tag_mem [lines];
    logic [xlen-1:0]        data_mem [lines];
    logic [word_addr_w-1:0] lookup_q;

    logic [index_w-1:0] rd_idx;
    logic [tag_w-1:0]   rd_tag;
    logic [index_w-1:0] wr_idx;
    logic [tag_w-1:0]   wr_tag;
    logic               wr_line_hit;

    assign rd_idx = lookup_q[index_w-1:0];
    assign rd_tag = lookup_q[word_addr_w-1:index_w];
    assign wr_idx = write_addr[index_w-1:0];
    assign wr_tag = write_addr[word_addr_w-1:index_w];

    // arrays are read after the registered lookup address.
    assign hit = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign rdata = data_mem[rd_idx];

    assign wr_line_hit = valid_q[wr_idx] && (tag_mem[wr_idx] == wr_tag);

    always_ff @(posedge clk) begin
        lookup_q <= lookup_addr;
        if (write_en && (fill || wr_line_hit)) begin
            for (int b = 0; b < strb_w; b++) begin
                if (write_strb[b])
                    data_mem[wr_idx][8*b +: 8] <= write_data[8*b +: 8];
            end
            if (fill)
                tag_mem[wr_idx] <= wr_tag; // new owner of the line.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (write_en && fill) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/bus_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_port import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_req,
    input  logic [word_addr_w-1:0] rd_addr,
    output logic                   rd_done,
    output logic [xlen-1:0]        rd_data,
    output axi_resp_t              rd_resp,
    input  logic                   wr_req,
    input  logic [word_addr_w-1:0] wr_addr,
    input  logic [xlen-1:0]        wr_data,
    input  logic [strb_w-1:0]      wr_strb,
    output logic                   wr_done,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [addr_w-1:0]      araddr,
    output logic [2:0]             arprot,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic [xlen-1:0]        rdata,
    input  axi_resp_t              rresp,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [addr_w-1:0]      awaddr,
    output logic [2:0]             awprot,
    output logic                   wvalid,
    input  logic                   wready,
    output logic [xlen-1:0]        wdata,
    output logic [strb_w-1:0]      wstrb,
    input  logic                   bvalid,
    output logic                   bready,
    input  axi_resp_t              bresp
);

    typedef enum logic [1:0] {bp_idle, bp_raddr, bp_rdata, bp_write} bp_state_t;

    bp_state_t              state;
    logic [word_addr_w-1:0] addr_q;
    logic [xlen-1:0]        wdata_q;
    logic [strb_w-1:0]      wstrb_q;
    logic                   aw_done;
    logic                   w_done;

    // read request goes out in the cycle it arrives, address from the port.
    assign arvalid = (state == bp_idle && rd_req) || state == bp_raddr;
    assign araddr = {(state == bp_idle) ? rd_addr : addr_q, {offset_w{1'b0}}};
    assign arprot = 3'b000;

    assign rready = state == bp_rdata;
    assign rd_done = rready && rvalid;
    assign rd_data = rdata;
    assign rd_resp = rresp;

    assign awvalid = state == bp_write && !aw_done;
    assign wvalid = state == bp_write && !w_done;
    assign awaddr = {addr_q, {offset_w{1'b0}}};
    assign awprot = 3'b000;
    assign wdata = wdata_q;
    assign wstrb = wstrb_q;
    // both channels finished, in whichever order.
    assign wr_done = state == bp_write && (aw_done || awready) && (w_done || wready);

    assign bready = 1'b1; // responses are drained, never checked.

    always_ff @(posedge clk) begin
        if (wr_req) begin
            addr_q <= wr_addr;
            wdata_q <= wr_data;
            wstrb_q <= wr_strb;
        end else if (state == bp_idle && rd_req) begin
            addr_q <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= bp_idle;
            aw_done <= 1'b0;
            w_done <= 1'b0;
        end else if (wr_req) begin
            // may land in the completion cycle of the previous access.
            state <= bp_write;
            aw_done <= 1'b0;
            w_done <= 1'b0;
        end else begin
            case (state)
                bp_idle: if (rd_req) state <= arready ? bp_rdata : bp_raddr;
                bp_raddr: if (arready) state <= bp_rdata;
                bp_rdata: if (rvalid) state <= bp_idle;
                bp_write: begin
                    if (wr_done) begin
                        state <= bp_idle;
                        aw_done <= 1'b0;
                        w_done <= 1'b0;
                    end else begin
                        if (awvalid && awready) aw_done <= 1'b1;
                        if (wvalid && wready) w_done <= 1'b1;
                    end
                end
                default: state <= bp_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/load_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_store import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   prev_stalled,
    output logic                   stall_next,
    input  logic [word_addr_w-1:0] addr,
    input  logic                   do_load,
    input  logic                   do_store,
    input  logic [xlen-1:0]        store_data,
    input  logic [strb_w-1:0]      store_mask,
    output logic [xlen-1:0]        load_data,
    output logic                   access_fault,
    output logic [word_addr_w-1:0] lookup_addr,
    input  logic                   hit,
    input  logic [xlen-1:0]        cache_rdata,
    output logic                   write_en,
    output logic [word_addr_w-1:0] write_addr,
    output logic [xlen-1:0]        write_data,
    output logic [strb_w-1:0]      write_strb,
    output logic                   fill,
    output logic                   rd_req,
    output logic [word_addr_w-1:0] rd_addr,
    input  logic                   rd_done,
    input  logic [xlen-1:0]        rd_data,
    input  axi_resp_t              rd_resp,
    output logic                   wr_req,
    output logic [word_addr_w-1:0] wr_addr,
    output logic [xlen-1:0]        wr_data,
    output logic [strb_w-1:0]      wr_strb,
    input  logic                   wr_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_load_check,
        st_load_wait,
        st_store_wait
    } state_t;

    state_t                 state;
    logic [word_addr_w-1:0] addr_buf;
    logic                   done;
    logic                   accept;
    logic                   store_wr;
    logic                   fill_ok;

    // completion of the current access.
    always_comb begin
        case (state)
            st_load_check: done = hit;
            st_load_wait:  done = rd_done;
            st_store_wait: done = wr_done;
            default:       done = 1'b0;
        endcase
    end

    assign stall_next = !done;
    assign accept = !prev_stalled && (do_load || do_store) && (state == st_idle || done);

    assign lookup_addr = accept ? addr : addr_buf;

    // miss found in the check cycle.
    assign rd_req = state == st_load_check && !hit;
    assign rd_addr = addr_buf;

    assign load_data = (state == st_load_wait) ? rd_data : cache_rdata;
    assign access_fault = state == st_load_wait && rd_done && rd_resp != resp_okay;

    // store goes to the bus and the cache straight from the core inputs.
    assign store_wr = accept && do_store;
    assign wr_req = store_wr;
    assign wr_addr = addr;
    assign wr_data = store_data;
    assign wr_strb = store_mask;

    // a store chained into the fill cycle takes the write port.
    // the line then just stays cold.
    assign fill_ok = state == st_load_wait && rd_done && rd_resp == resp_okay && !store_wr;

    assign write_en = store_wr || fill_ok;
    assign fill = !store_wr;
    assign write_addr = store_wr ? addr : addr_buf;
    assign write_data = store_wr ? store_data : rd_data;
    assign write_strb = store_wr ? store_mask : {strb_w{1'b1}};

    always_ff @(posedge clk) begin
        if (accept)
            addr_buf <= addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else if (accept) begin
            state <= do_store ? st_store_wait : st_load_check;
        end else if (done) begin
            state <= st_idle;
        end else if (state == st_load_check) begin
            state <= st_load_wait; // miss.
        end
    end

endmodule

`default_nettype wire

// ==== design/lsu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int index_w = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   prev_stalled,
    output logic                   stall_next,
    input  logic [word_addr_w-1:0] addr,
    input  logic                   do_load,
    input  logic                   do_store,
    input  logic [xlen-1:0]        store_data,
    input  logic [strb_w-1:0]      store_mask,
    output logic [xlen-1:0]        load_data,
    output logic                   access_fault,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [addr_w-1:0]      araddr,
    output logic [2:0]             arprot,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic [xlen-1:0]        rdata,
    input  axi_resp_t              rresp,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [addr_w-1:0]      awaddr,
    output logic [2:0]             awprot,
    output logic                   wvalid,
    input  logic                   wready,
    output logic [xlen-1:0]        wdata,
    output logic [strb_w-1:0]      wstrb,
    input  logic                   bvalid,
    output logic                   bready,
    input  axi_resp_t              bresp
);

    // controller to cache.
    logic [word_addr_w-1:0] lookup_addr;
    logic                   hit;
    logic [xlen-1:0]        cache_rdata;
    logic                   write_en;
    logic [word_addr_w-1:0] write_addr;
    logic [xlen-1:0]        write_data;
    logic [strb_w-1:0]      write_strb;
    logic                   fill;

    // controller to bus port.
    logic                   rd_req;
    logic [word_addr_w-1:0] rd_addr;
    logic                   rd_done;
    logic [xlen-1:0]        rd_data;
    axi_resp_t              rd_resp;
    logic                   wr_req;
    logic [word_addr_w-1:0] wr_addr;
    logic [xlen-1:0]        wr_data;
    logic [strb_w-1:0]      wr_strb;
    logic                   wr_done;

    data_cache #(.index_w(index_w)) cache0 (
        .clk, .rst,
        .lookup_addr, .hit, .rdata(cache_rdata),
        .write_en, .write_addr, .write_data, .write_strb, .fill
    );

    bus_port bus0 (
        .clk, .rst,
        .rd_req, .rd_addr, .rd_done, .rd_data, .rd_resp,
        .wr_req, .wr_addr, .wr_data, .wr_strb, .wr_done,
        .arvalid, .arready, .araddr, .arprot,
        .rvalid, .rready, .rdata, .rresp,
        .awvalid, .awready, .awaddr, .awprot,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp
    );

    load_store ctrl0 (
        .clk, .rst,
        .prev_stalled, .stall_next,
        .addr, .do_load, .do_store, .store_data, .store_mask,
        .load_data, .access_fault,
        .lookup_addr, .hit, .cache_rdata,
        .write_en, .write_addr, .write_data, .write_strb, .fill,
        .rd_req, .rd_addr, .rd_done, .rd_data, .rd_resp,
        .wr_req, .wr_addr, .wr_data, .wr_strb, .wr_done
    );

endmodule

`default_nettype wire

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model import lsu_pkg::*; #(
    parameter logic [xlen-1:0] init_mult = 64'h1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              arvalid,
    output logic              arready,
    input  logic [addr_w-1:0] araddr,
    output logic              rvalid,
    input  logic              rready,
    output logic [xlen-1:0]   rdata,
    output axi_resp_t         rresp,
    input  logic              awvalid,
    output logic              awready,
    input  logic [addr_w-1:0] awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [xlen-1:0]   wdata,
    input  logic [strb_w-1:0] wstrb,
    output logic              bvalid,
    input  logic              bready,
    output axi_resp_t         bresp,
    output int                ar_count
);

    logic [xlen-1:0]   mem [256];
    integer            seed;
    int                ar_wait;
    int                r_wait;
    int                aw_wait;
    int                w_wait;
    logic              r_pend;
    logic              r_fault;
    logic              aw_got;
    logic              w_got;
    logic [7:0]        r_idx;
    logic [7:0]        w_idx;
    logic [xlen-1:0]   w_word;
    logic [strb_w-1:0] w_mask;

    function automatic int pick_delay();
        return $random(seed) & 3; // 0 to 3 cycles.
    endfunction

    initial begin
        seed = 55;
        for (int i = 0; i < 256; i++)
            mem[i] = init_mult * i;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = resp_okay;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = resp_okay;
        ar_count = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            ar_count <= 0;
            r_pend = 1'b0;
            aw_got = 1'b0;
            w_got = 1'b0;
            ar_wait = 0;
            aw_wait = 0;
            w_wait = 0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_count <= ar_count + 1;
                r_idx = araddr[offset_w +: 8];
                r_fault = araddr[addr_w-1:offset_w] >= 'h80; // fault region.
                r_wait = pick_delay();
                r_pend = 1'b1;
                ar_wait = pick_delay();
            end else if (arvalid) begin
                if (ar_wait == 0)
                    arready <= 1'b1;
                else
                    ar_wait--;
            end

            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pend) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                    rdata <= mem[r_idx];
                    rresp <= r_fault ? resp_slverr : resp_okay;
                    r_pend = 1'b0;
                end else begin
                    r_wait--;
                end
            end

            // aw and w are taken independently.
            if (awvalid && awready) begin
                awready <= 1'b0;
                w_idx = awaddr[offset_w +: 8];
                aw_got = 1'b1;
                aw_wait = pick_delay();
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 0)
                    awready <= 1'b1;
                else
                    aw_wait--;
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_word = wdata;
                w_mask = wstrb;
                w_got = 1'b1;
                w_wait = pick_delay();
            end else if (wvalid && !w_got) begin
                if (w_wait == 0)
                    wready <= 1'b1;
                else
                    w_wait--;
            end

            if (bvalid && bready)
                bvalid <= 1'b0;
            if (aw_got && w_got) begin
                for (int b = 0; b < strb_w; b++) begin
                    if (w_mask[b])
                        mem[w_idx][8*b +: 8] = w_word[8*b +: 8];
                end
                aw_got = 1'b0;
                w_got = 1'b0;
                bvalid <= 1'b1;
                bresp <= resp_okay;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_lsu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

    localparam logic [xlen-1:0] mem_mult = 64'h9e37_79b9_7f4a_7c15;
    localparam int max_accesses = 200;
    localparam int cycles_per_access = 20;
    localparam int timeout_cycles = max_accesses * cycles_per_access + 2000;

    logic                   clk;
    logic                   rst;
    logic                   prev_stalled;
    logic                   stall_next;
    logic [word_addr_w-1:0] addr;
    logic                   do_load;
    logic                   do_store;
    logic [xlen-1:0]        store_data;
    logic [strb_w-1:0]      store_mask;
    logic [xlen-1:0]        load_data;
    logic                   access_fault;

    // axi between dut and memory model.
    logic                   arvalid;
    logic                   arready;
    logic [addr_w-1:0]      araddr;
    logic [2:0]             arprot;
    logic                   rvalid;
    logic                   rready;
    logic [xlen-1:0]        rdata;
    axi_resp_t              rresp;
    logic                   awvalid;
    logic                   awready;
    logic [addr_w-1:0]      awaddr;
    logic [2:0]             awprot;
    logic                   wvalid;
    logic                   wready;
    logic [xlen-1:0]        wdata;
    logic [strb_w-1:0]      wstrb;
    logic                   bvalid;
    logic                   bready;
    axi_resp_t              bresp;
    int                     ar_count;

    logic [xlen-1:0] ref_mem [256];
    integer          seed;
    int              errors;
    int              tests;
    int              cycle_count;
    logic [xlen-1:0] got_data;
    logic            got_fault;
    int              got_cycles;

    lsu_top #(.index_w(4)) dut0 (.*);
    axi_mem_model #(.init_mult(mem_mult)) mem0 (.*);

    always #50 clk = ~clk;

    function automatic logic [xlen-1:0] merge_bytes(input logic [xlen-1:0] old_word,
                                                    input logic [xlen-1:0] new_word,
                                                    input logic [strb_w-1:0] mask);
        logic [xlen-1:0] w;
        w = old_word;
        for (int b = 0; b < strb_w; b++) begin
            if (mask[b])
                w[8*b +: 8] = new_word[8*b +: 8];
        end
        return w;
    endfunction

    task automatic report_value(input string name, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] exp);
        $display("ERR %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic end_test(input string name, input int start);
        tests++;
        $display("%s: %0d errors", name, errors - start);
    endtask

    // called at posedge+1 of an idle or completing cycle; returns in the completion cycle.
    task automatic run_access(input logic store, input logic [word_addr_w-1:0] a,
                              input logic [xlen-1:0] d, input logic [strb_w-1:0] m);
        addr = a;
        do_load = !store;
        do_store = store;
        store_data = d;
        store_mask = m;
        prev_stalled = 1'b0;
        @(posedge clk);
        #1;
        prev_stalled = 1'b1;
        do_load = 1'b0;
        do_store = 1'b0;
        got_cycles = 1;
        while (stall_next) begin
            @(posedge clk);
            #1;
            got_cycles++;
        end
        got_data = load_data;
        got_fault = access_fault;
    endtask

    task automatic load_check(input logic [word_addr_w-1:0] a);
        run_access(1'b0, a, '0, '0);
        if (got_data !== ref_mem[a[7:0]])
            report_value("load_data", got_data, ref_mem[a[7:0]]);
        if (got_fault !== 1'b0)
            report_value("access_fault", got_fault, 0);
    endtask

    task automatic store_word(input logic [word_addr_w-1:0] a, input logic [xlen-1:0] d,
                              input logic [strb_w-1:0] m);
        run_access(1'b1, a, d, m);
        ref_mem[a[7:0]] = merge_bytes(ref_mem[a[7:0]], d, m);
    endtask

    task automatic reset_outputs();
        int start;
        start = errors;
        if (stall_next !== 1'b1)
            report_value("stall_next", stall_next, 1);
        if (arvalid !== 1'b0)
            report_value("arvalid", arvalid, 0);
        if (awvalid !== 1'b0)
            report_value("awvalid", awvalid, 0);
        if (wvalid !== 1'b0)
            report_value("wvalid", wvalid, 0);
        if (arprot !== 3'b000)
            report_value("arprot", arprot, 0);
        if (awprot !== 3'b000)
            report_value("awprot", awprot, 0);
        end_test("reset_outputs", start);
    endtask

    task automatic load_miss_then_hit();
        int start;
        int reads;
        start = errors;
        reads = ar_count;
        load_check(29'h05);
        if (ar_count != reads + 1)
            report_value("ar_count", ar_count, reads + 1);
        load_check(29'h05); // chained reload.
        if (ar_count != reads + 1)
            report_value("ar_count", ar_count, reads + 1);
        if (got_cycles != 1) begin
            $display("cached reload took %0d cycles instead of one", got_cycles);
            errors++;
        end
        end_test("load_miss_then_hit", start);
    endtask

    task automatic store_uncached_merge();
        int start;
        start = errors;
        store_word(29'h21, 64'hdead_beef_cafe_f00d, 8'b1010_0101);
        load_check(29'h21);
        // memory takes the word at the last handshake edge.
        if (mem0.mem[8'h21] !== ref_mem[8'h21])
            report_value("mem0.mem", mem0.mem[8'h21], ref_mem[8'h21]);
        end_test("store_uncached_merge", start);
    endtask

    task automatic store_hit_update();
        int start;
        int reads;
        start = errors;
        reads = ar_count;
        store_word(29'h05, 64'h0011_2233_4455_6677, 8'h3c);
        load_check(29'h05);
        if (ar_count != reads)
            report_value("ar_count", ar_count, reads);
        end_test("store_hit_update", start);
    endtask

    task automatic fault_region_reload();
        int start;
        int reads;
        start = errors;
        reads = ar_count;
        for (int k = 1; k <= 2; k++) begin
            run_access(1'b0, 29'h90, '0, '0);
            if (got_fault !== 1'b1)
                report_value("access_fault", got_fault, 1);
            if (ar_count != reads + k)
                report_value("ar_count", ar_count, reads + k);
        end
        end_test("fault_region_reload", start);
    endtask

    task automatic index_eviction();
        int start;
        int reads;
        start = errors;
        for (int k = 0; k < 3; k++) begin
            reads = ar_count;
            load_check(29'h13);
            load_check(29'h33); // same index, other tag.
            if (ar_count != reads + 2)
                report_value("ar_count", ar_count, reads + 2);
        end
        end_test("index_eviction", start);
    endtask

    task automatic random_traffic();
        int start;
        logic [word_addr_w-1:0] a;
        logic [xlen-1:0] d;
        logic [strb_w-1:0] m;
        start = errors;
        for (int n = 0; n < 150; n++) begin
            a = word_addr_w'($random(seed) & 'h3f);
            d = {$random(seed), $random(seed)};
            m = strb_w'($random(seed));
            if ($random(seed) & 1)
                store_word(a, d, m);
            else
                load_check(a);
        end
        end_test("random_traffic", start);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, no end of tests within %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        seed = 55;
        errors = 0;
        tests = 0;
        clk = 1'b0;
        rst = 1'b1;
        prev_stalled = 1'b1;
        addr = '0;
        do_load = 1'b0;
        do_store = 1'b0;
        store_data = '0;
        store_mask = '0;
        for (int i = 0; i < 256; i++)
            ref_mem[i] = mem_mult * i;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_outputs();
        load_miss_then_hit();
        store_uncached_merge();
        store_hit_update();
        fault_region_reload();
        index_eviction();
        random_traffic();
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/lsu_pkg.sv
design/data_cache.sv
design/bus_port.sv
design/load_store.sv
design/lsu_top.sv
bench/axi_mem_model.sv
bench/tb_lsu.sv
